// File: list.f
+incdir+include
hdl/memtest_pkg.sv
hdl/ddrAdrsGen.sv
hdl/patternGen.sv
hdl/memTestSeq.sv
hdl/dataChecker.sv
hdl/memTestTop.sv
verif/memTestAssertions.sv
verif/memTestTb.sv

// File: run.sh
#!/bin/bash
# build and run the memory test engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module memTestTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q -x ">>> PASS" \
	|| exit 1
exit 0

// File: verif/memtest_golden.txt
# name mode seed faultIdx faultMask latency randomReady expErrCount expFirstErrAdrs
# mode 0 adrs, 1 inverted adrs, 2 walking one, 3 seed; all numbers but mode, idx, lat in hex
adrsClean    0 00000000 0  0000000000000000 1 0 0 000000000
invClean     1 12345678 0  0000000000000000 2 0 0 000000000
walkClean    2 00000000 0  0000000000000000 3 0 0 000000000
seedClean    3 deadbeef 0  0000000000000000 1 0 0 000000000
# single bit faults
adrsFault    0 a5a5a5a5 5  0000000000000100 2 0 1 000200040
walkFault    2 00000000 37 8000000000000000 4 0 1 000202040
# random ready and long latency
bpAdrs       0 0f0f0f0f 0  0000000000000000 6 1 0 000000000
bpInv        1 12345678 0  0000000000000000 5 1 0 000000000
bpWalk       2 00000000 0  0000000000000000 6 1 0 000000000
bpSeed       3 deadbeef 0  0000000000000000 6 1 0 000000000
bpFault      1 c3c3c3c3 63 0000000000000001 6 1 1 0006030c0
# restart after a failing run
restartClean 0 00000000 0  0000000000000000 1 0 0 000000000

// File: verif/memTestTb.sv
`include "memtest_consts.svh"

module memTestTb
	import memtest_pkg::*;
;

	localparam int lpWords = 64;  // 4 rows x 4 cols x 4 banks

	logic iCLK, iRST, iStart, iMemReady, iRdValid;
	patMode_t iMode;
	logic [31:0] iSeed;
	data_t iRdData;
	logic oBusy, oDone, oErrAny, oWrEn, oRdEn;
	logic [`MT_ERRCNT_BITS-1:0] oErrCount;
	adrs_t oFirstErrAdrs, oMemAdrs;
	data_t oErrBits, oWrData;

	data_t mem [lpWords];
	data_t rdDataQ [$];   // returns in order
	int rdDueQ [$];
	int cycle, wrCnt, rdCnt, doneCnt, errCnt, checkCnt;
	int faultIdx, latency, randReady;
	data_t faultMask;
	logic [31:0] lfsr;
	logic rdyD1, rdyD2;   // ready history, strobe trails step by 2

	memTestTop #(.pRowBits(8), .pColBits(6), .pBankBits(2), .pRowStep(64), .pColStep(16)) UUT (
		.iCLK(iCLK), .iRST(iRST), .iStart(iStart), .iMode(iMode), .iSeed(iSeed),
		.oBusy(oBusy), .oDone(oDone), .oErrCount(oErrCount), .oFirstErrAdrs(oFirstErrAdrs),
		.oErrBits(oErrBits), .oErrAny(oErrAny), .oWrEn(oWrEn), .oRdEn(oRdEn),
		.oMemAdrs(oMemAdrs), .oWrData(oWrData), .iMemReady(iMemReady),
		.iRdValid(iRdValid), .iRdData(iRdData)
	);

	always #5 iCLK = ~iCLK;

	// --------------------
	// helpers
	// --------------------
	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		checkCnt++;
		if (exp !== act)
		begin
			errCnt++;
			$display("ERR %0s expected %h actual %h", name, exp, act);
		end
	endtask

	// fibonacci, taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// sweep position n: row fastest, then column, then bank
	function automatic adrs_t idxToAdrs(input int n);
		logic [16:0] row;
		logic [2:0] bank;
		logic [9:0] col;
		row = 17'((n % 4) * 64);
		col = 10'(((n / 4) % 4) * 16);
		bank = 3'(n / 16);
		return {1'b0, row, bank, col, 2'b00};
	endfunction

	function automatic int adrsToIdx(input adrs_t a);
		return int'(a[14:12]) * 16 + int'(a[11:2] / 16) * 4 + int'(a[31:15] / 64);
	endfunction

	function automatic data_t expWord(input patMode_t m, input logic [31:0] s, input adrs_t a,
		input int n);
		data_t w;
		w = {a[31:0], a[31:0]} ^ {s, s};
		case (m)
			PAT_ADRS:     return w;
			PAT_INV_ADRS: return ~w;
			PAT_WALK:     return data_t'(1) << (n % 64);
			default:      return {s, s};
		endcase
	endfunction

	// --------------------
	// memory model
	// --------------------
	always @(posedge iCLK)
	begin
		cycle++;
		if (oDone) doneCnt++;
		rdyD1 <= iMemReady;
		rdyD2 <= rdyD1;
		if ((oWrEn || oRdEn) && !rdyD2 && !iRST)
		begin
			errCnt++;
			$display("strobe issued from a step taken while memory was not ready");
		end
		// return side first, latency is at least one
		if (rdDueQ.size() > 0 && rdDueQ[0] <= cycle)
		begin
			iRdValid <= 1'b1;
			iRdData <= rdDataQ.pop_front();
			void'(rdDueQ.pop_front());
		end
		else
			iRdValid <= 1'b0;
		if (oWrEn)
		begin
			compare("wrAdrs", 64'(idxToAdrs(wrCnt)), 64'(oMemAdrs));
			compare("wrData", expWord(iMode, iSeed, idxToAdrs(wrCnt), wrCnt), oWrData);
			mem[adrsToIdx(oMemAdrs)] = oWrData ^
				((adrsToIdx(oMemAdrs) == faultIdx) ? faultMask : '0);  // injected fault
			wrCnt++;
		end
		if (oRdEn)
		begin
			compare("rdAdrs", 64'(idxToAdrs(rdCnt)), 64'(oMemAdrs));
			rdDataQ.push_back(mem[adrsToIdx(oMemAdrs)]);
			rdDueQ.push_back(cycle + latency);
			rdCnt++;
		end
		iMemReady <= (randReady != 0) ? lfsrBit() : 1'b1;
	end

	// --------------------
	// test flow
	// --------------------
	initial
	begin
		int fd, n, modeVal, fIdx, lat, rnd, expCnt, waitCnt, doneBase, runs;
		logic [31:0] seed;
		logic [63:0] fMask;
		adrs_t expFirst;
		string name;
		string line;
		logic timedOut;

		iCLK = 0;
		iRST = 1;
		iStart = 0;
		iMemReady = 1;
		iRdValid = 0;
		iRdData = '0;
		iMode = PAT_ADRS;
		iSeed = '0;
		lfsr = 32'ha990_6093;
		rdyD1 = 1;
		rdyD2 = 1;
		faultIdx = 0;
		faultMask = '0;
		latency = 1;
		randReady = 0;
		timedOut = 0;
		runs = 0;
		foreach (mem[i]) mem[i] = '0;
		repeat (2) @(posedge iCLK);
		iRST <= 0;

		fd = $fopen("verif/memtest_golden.txt", "r");
		if (fd == 0)
		begin
			errCnt++;
			$display("golden file could not be opened");
		end
		while (fd != 0 && !timedOut && $fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#") continue;  // comment or blank
			n = $sscanf(line, "%s %d %h %d %h %d %h %h %h", name, modeVal, seed, fIdx, fMask,
				lat, rnd, expCnt, expFirst);
			if (n != 9) continue;
			@(posedge iCLK);
			iMode <= patMode_t'(modeVal[1:0]);
			iSeed <= seed;
			faultIdx = fIdx;
			faultMask = fMask;
			latency = lat;
			randReady = rnd;
			wrCnt = 0;
			rdCnt = 0;
			doneBase = doneCnt;
			@(posedge iCLK);
			iStart <= 1'b1;
			@(posedge iCLK);
			iStart <= 1'b0;
			@(posedge iCLK);
			// start edge raised busy and wiped the last run's errors
			compare({name, "_startBusy"}, 1, oBusy);
			compare({name, "_startErrCount"}, 0, oErrCount);
			compare({name, "_startFirstErr"}, 0, 64'(oFirstErrAdrs));
			compare({name, "_startErrBits"}, 0, oErrBits);
			compare({name, "_startErrAny"}, 0, oErrAny);
			waitCnt = 0;
			while (doneCnt == doneBase && waitCnt < 5000)
			begin
				@(posedge iCLK);
				waitCnt++;
			end
			if (doneCnt == doneBase)
			begin
				timedOut = 1;
				$display("timeout waiting for done in test %0s", name);
				break;
			end
			randReady = 0;
			repeat (4) @(posedge iCLK);  // a second done would show here
			runs++;
			compare({name, "_writes"}, lpWords, wrCnt);
			compare({name, "_reads"}, lpWords, rdCnt);
			compare({name, "_dones"}, 1, doneCnt - doneBase);
			compare({name, "_errCount"}, expCnt, oErrCount);
			compare({name, "_firstErr"}, 64'(expFirst), 64'(oFirstErrAdrs));
			compare({name, "_errBits"}, (expCnt != 0) ? fMask : 64'd0, oErrBits);
			compare({name, "_errAny"}, expCnt != 0, oErrAny);
			compare({name, "_busy"}, 0, oBusy);
		end
		if (fd != 0) $fclose(fd);
		if (runs == 0 && !timedOut)
		begin
			errCnt++;
			$display("no test lines were run");
		end

		$display("tests %0d checks %0d errors %0d timeouts %0d", runs, checkCnt, errCnt,
			timedOut);
		if (errCnt == 0 && !timedOut)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: verif/memTestAssertions.sv
`include "memtest_consts.svh"

module memTestAssertions
(
	input logic                                  iCLK,
	input logic                                  iRST,
	input logic                                  step,      // generator step
	input logic                                  adrsDone,  // generator done pulse
	input logic                                  rdValid,   // one read returned
	input logic [$clog2(`MT_INFLIGHT + 1)-1:0]   inflight
);

	// every return matches a read still outstanding
	aRdReturn: assert property (@(posedge iCLK) disable iff (iRST) rdValid |-> inflight != '0)
		else $error("read returned with no read outstanding");

	aInflight: assert property (@(posedge iCLK) disable iff (iRST) inflight <= `MT_INFLIGHT)
		else $error("reads in flight above limit");

	// generator done only right after the step that took the last address
	aAdrsDone: assert property (@(posedge iCLK) disable iff (iRST) adrsDone |-> $past(step))
		else $error("address done without a step before it");

endmodule

bind memTestSeq memTestAssertions uAsrt (
	.iCLK(iCLK), .iRST(iRST), .step(oStep), .adrsDone(iAdrsDone), .rdValid(iRdValid),
	.inflight(rInflight)
);

// File: hdl/memTestTop.sv
`include "memtest_consts.svh"

module memTestTop
	import memtest_pkg::*;
#(
	parameter int pRowBits  = `MT_ROW_BITS,
	parameter int pColBits  = `MT_COL_BITS,
	parameter int pBankBits = `MT_BANK_BITS,
	parameter int pRowStep  = `MT_BUS_BYTES,
	parameter int pColStep  = `MT_BURST
)(
	input  logic                        iCLK,
	input  logic                        iRST,
	// control and status
	input  logic                        iStart,
	input  patMode_t                    iMode,
	input  logic [31:0]                 iSeed,
	output logic                        oBusy,
	output logic                        oDone,
	output logic [`MT_ERRCNT_BITS-1:0]  oErrCount,
	output adrs_t                       oFirstErrAdrs,
	output data_t                       oErrBits,
	output logic                        oErrAny,
	// memory strobes
	output logic                        oWrEn,
	output logic                        oRdEn,
	output adrs_t                       oMemAdrs,
	output data_t                       oWrData,
	input  logic                        iMemReady,
	input  logic                        iRdValid,
	input  data_t                       iRdData
);

	logic                              wStep;
	logic                              wClr;
	logic                              wIssue;
	logic                              wWrite;
	logic [$clog2(`MT_DATA_BITS)-1:0]  wIndex;
	adrs_t                             wAdrs;
	logic                              wAdrsDone;
	logic                              wPgValid;
	logic                              wPgWrite;
	adrs_t                             wPgAdrs;
	data_t                             wPgData;

	memTestSeq uSeq (
		.iCLK(iCLK), .iRST(iRST), .iStart(iStart), .iMemReady(iMemReady),
		.iRdValid(iRdValid), .iAdrsDone(wAdrsDone), .oStep(wStep), .oClr(wClr),
		.oIssue(wIssue), .oWrite(wWrite), .oIndex(wIndex), .oBusy(oBusy), .oDone(oDone)
	);

	ddrAdrsGen #(
		.pRowBits(pRowBits), .pColBits(pColBits), .pBankBits(pBankBits),
		.pRowStep(pRowStep), .pColStep(pColStep)
	) uAdrsGen (
		.iCLK(iCLK), .iRST(iRST), .iClr(wClr), .iStep(wStep),
		.oAdrs(wAdrs), .oAdrsDone(wAdrsDone)
	);

	patternGen uPat (
		.iCLK(iCLK), .iRST(iRST), .iValid(wIssue), .iWrite(wWrite), .iAdrs(wAdrs),
		.iIndex(wIndex), .iMode(iMode), .iSeed(iSeed), .oValid(wPgValid),
		.oWrite(wPgWrite), .oAdrs(wPgAdrs), .oData(wPgData)
	);

	// checker sees the same stage as the memory
	dataChecker uChk (
		.iCLK(iCLK), .iRST(iRST), .iClr(wClr), .iPush(wPgValid & ~wPgWrite),
		.iExpAdrs(wPgAdrs), .iExpData(wPgData), .iRdValid(iRdValid), .iRdData(iRdData),
		.oErrCount(oErrCount), .oFirstErrAdrs(oFirstErrAdrs), .oErrBits(oErrBits),
		.oErrAny(oErrAny)
	);

	// strobes straight off the pattern register
	assign oWrEn    = wPgValid & wPgWrite;
	assign oRdEn    = wPgValid & ~wPgWrite;
	assign oMemAdrs = wPgAdrs;
	assign oWrData  = wPgData;

endmodule

// File: hdl/dataChecker.sv
`include "memtest_consts.svh"

module dataChecker
	import memtest_pkg::*;
(
	input  logic                        iCLK,
	input  logic                        iRST,
	input  logic                        iClr,      // new run
	input  logic                        iPush,     // read strobe leaving
	input  adrs_t                       iExpAdrs,
	input  data_t                       iExpData,
	input  logic                        iRdValid,
	input  data_t                       iRdData,
	output logic [`MT_ERRCNT_BITS-1:0]  oErrCount,
	output adrs_t                       oFirstErrAdrs,
	output data_t                       oErrBits,
	output logic                        oErrAny
);

	localparam int lpDepth   = `MT_INFLIGHT;
	localparam int lpPtrBits = $clog2(lpDepth);
	localparam int lpCntBits = $clog2(lpDepth + 1);

	data_t                       rExpData [lpDepth];  // expected words, in read order
	adrs_t                       rExpAdrs [lpDepth];
	logic [lpPtrBits-1:0]        rWrPtr;
	logic [lpPtrBits-1:0]        rRdPtr;
	logic [lpCntBits-1:0]        rCount;
	logic [`MT_ERRCNT_BITS-1:0]  rErrCount;
	adrs_t                       rFirstErrAdrs;
	data_t                       rErrBits;
	logic                        qPop;
	data_t                       qDiff;
	logic                        qMiss;

	assign qPop  = iRdValid & (rCount != '0);  // stray return ignored
	assign qDiff = iRdData ^ rExpData[rRdPtr];
	assign qMiss = qPop & (|qDiff);

	// --------------------
	// expected data fifo
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iPush)
		begin
			rExpData[rWrPtr] <= iExpData;
			rExpAdrs[rWrPtr] <= iExpAdrs;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST || iClr)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
		end
		else
		begin
			if (iPush) rWrPtr <= rWrPtr + 1'b1;
			if (qPop)  rRdPtr <= rRdPtr + 1'b1;
			rCount <= rCount + lpCntBits'(iPush) - lpCntBits'(qPop);
		end
	end

	// --------------------
	// error record
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST || iClr)
		begin
			rErrCount     <= '0;
			rFirstErrAdrs <= '0;
			rErrBits      <= '0;
		end
		else if (qMiss)
		begin
			if (rErrCount != '1) rErrCount <= rErrCount + 1'b1;  // saturate
			if (rErrCount == '0) rFirstErrAdrs <= rExpAdrs[rRdPtr];
			rErrBits <= rErrBits | qDiff;  // sticky failing bits
		end
	end

	assign oErrCount     = rErrCount;
	assign oFirstErrAdrs = rFirstErrAdrs;
	assign oErrBits      = rErrBits;
	assign oErrAny       = (rErrCount != '0);

endmodule

// File: hdl/memTestSeq.sv
`include "memtest_consts.svh"

module memTestSeq
	import memtest_pkg::*;
(
	input  logic                              iCLK,
	input  logic                              iRST,
	input  logic                              iStart,     // pulse, only seen in idle
	input  logic                              iMemReady,
	input  logic                              iRdValid,   // one read returned
	input  logic                              iAdrsDone,  // last address taken
	output logic                              oStep,      // advance address generator
	output logic                              oClr,       // restart generator and checker
	output logic                              oIssue,     // item for pattern stage
	output logic                              oWrite,
	output logic [$clog2(`MT_DATA_BITS)-1:0]  oIndex,
	output logic                              oBusy,
	output logic                              oDone
);

	localparam int lpCntBits = $clog2(`MT_INFLIGHT + 1);
	localparam int lpIdxBits = $clog2(`MT_DATA_BITS);

	seqState_t              rState;
	logic [lpCntBits-1:0]   rInflight;       // reads stepped but not returned
	logic [lpCntBits-1:0]   qInflightNext;
	logic [lpIdxBits-1:0]   rStepCnt;        // steps since pass began
	logic                   rIssue;
	logic                   rWrite;
	logic [lpIdxBits-1:0]   rIndex;
	logic                   rBusy;
	logic                   rDone;
	logic                   qWrStep;
	logic                   qRdStep;

	// --------------------
	// step decision
	// --------------------
	always_comb
	begin
		// no step in the done cycle, the generator has already wrapped
		qWrStep = (rState == WRITE) & iMemReady & ~iAdrsDone;
		qRdStep = (rState == READ) & iMemReady & ~iAdrsDone
		          & (rInflight < lpCntBits'(`MT_INFLIGHT));
		oStep   = qWrStep | qRdStep;
		// clear on start and again at the write to read turn
		oClr    = ((rState == IDLE) & iStart) | ((rState == WRITE) & iAdrsDone);
		qInflightNext = rInflight + lpCntBits'(qRdStep) - lpCntBits'(iRdValid);
	end

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rState    <= IDLE;
			rBusy     <= 1'b0;
			rDone     <= 1'b0;
			rInflight <= '0;
		end
		else
		begin
			rDone     <= 1'b0;  // single cycle pulse
			rInflight <= qInflightNext;
			case (rState)
				IDLE:
				begin
					if (iStart)
					begin
						rState <= WRITE;
						rBusy  <= 1'b1;
					end
				end
				WRITE:
				begin
					if (iAdrsDone) rState <= READ;
				end
				READ:
				begin
					if (iAdrsDone) rState <= DRAIN;
				end
				DRAIN:
				begin
					// finish right after the last return
					if (qInflightNext == '0)
					begin
						rState <= IDLE;
						rBusy  <= 1'b0;
						rDone  <= 1'b1;
					end
				end
				default: rState <= IDLE;
			endcase
		end
	end

	// word index, restarts with each pass
	always_ff @(posedge iCLK)
	begin
		if (iRST || oClr)
			rStepCnt <= '0;
		else if (oStep)
			rStepCnt <= rStepCnt + 1'b1;
	end

	// issue tag lines up with the generator output
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rIssue <= 1'b0;
		else
			rIssue <= oStep;
	end

	always_ff @(posedge iCLK)
	begin
		rWrite <= (rState == WRITE);
		rIndex <= rStepCnt;  // index of the address just taken
	end

	assign oIssue = rIssue;
	assign oWrite = rWrite;
	assign oIndex = rIndex;
	assign oBusy  = rBusy;
	assign oDone  = rDone;

endmodule

// File: hdl/patternGen.sv
`include "memtest_consts.svh"

module patternGen
	import memtest_pkg::*;
(
	input  logic                              iCLK,
	input  logic                              iRST,
	input  logic                              iValid,  // item present
	input  logic                              iWrite,  // write tag, else read
	input  adrs_t                             iAdrs,
	input  logic [$clog2(`MT_DATA_BITS)-1:0]  iIndex,  // word index in pass
	input  patMode_t                          iMode,
	input  logic [31:0]                       iSeed,
	output logic                              oValid,
	output logic                              oWrite,
	output adrs_t                             oAdrs,
	output data_t                             oData
);

	data_t qAdrsWord;
	data_t qData;
	logic  rValid;
	logic  rWrite;
	adrs_t rAdrs;
	data_t rData;

	// low address word doubled, seed mixed in
	assign qAdrsWord = {iAdrs[31:0], iAdrs[31:0]} ^ {iSeed, iSeed};

	always_comb
	begin
		case (iMode)
			PAT_ADRS:     qData = qAdrsWord;
			PAT_INV_ADRS: qData = ~qAdrsWord;
			PAT_WALK:     qData = data_t'(1) << iIndex;  // index wraps at data width
			PAT_SEED:     qData = {iSeed, iSeed};
			default:      qData = '0;
		endcase
	end

	// --------------------
	// one stage pipeline
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rValid <= 1'b0;
		else
			rValid <= iValid;
	end

	// payload follows every cycle
	always_ff @(posedge iCLK)
	begin
		rWrite <= iWrite;
		rAdrs  <= iAdrs;
		rData  <= qData;
	end

	assign oValid = rValid;
	assign oWrite = rWrite;
	assign oAdrs  = rAdrs;
	assign oData  = rData;

endmodule

// File: hdl/ddrAdrsGen.sv
`include "memtest_consts.svh"

module ddrAdrsGen
	import memtest_pkg::*;
#(
	parameter int pRowBits  = `MT_ROW_BITS,
	parameter int pColBits  = `MT_COL_BITS,
	parameter int pBankBits = `MT_BANK_BITS,
	parameter int pRowStep  = `MT_BUS_BYTES,  // bytes per beat
	parameter int pColStep  = `MT_BURST       // burst length
)(
	input  logic  iCLK,
	input  logic  iRST,
	input  logic  iClr,      // back to address zero
	input  logic  iStep,     // take current address, advance
	output adrs_t oAdrs,     // address taken by last step
	output logic  oAdrsDone  // last address was taken
);

	// fixed field widths of the hard ip layout
	localparam int lpRowF  = `MT_ROW_MAX_BITS;
	localparam int lpBankF = `MT_BANK_BITS;
	localparam int lpColF  = `MT_COL_BITS;

	localparam logic [pRowBits-1:0]  lpRowStep = pRowBits'(pRowStep);
	localparam logic [pColBits-1:0]  lpColStep = pColBits'(pColStep);
	// last value before each field wraps
	localparam logic [pRowBits-1:0]  lpRowMax  = pRowBits'((2**pRowBits) - pRowStep);
	localparam logic [pColBits-1:0]  lpColMax  = pColBits'((2**pColBits) - pColStep);
	localparam logic [pBankBits-1:0] lpBankMax = '1;

	logic [pRowBits-1:0]  rRow;
	logic [pColBits-1:0]  rCol;
	logic [pBankBits-1:0] rBank;
	logic                 rAdrsDone;
	adrs_t                rAdrs;
	adrs_t                qAdrs;
	logic                 qRowMax;
	logic                 qColMax;
	logic                 qAdrsMax;

	// carry chain, each field gated by the one below
	always_comb
	begin
		qRowMax  = iStep & (rRow == lpRowMax);
		qColMax  = qRowMax & (rCol == lpColMax);
		qAdrsMax = qColMax & (rBank == lpBankMax);
	end

	// cs and top row bits stay zero, datapath bits zero
	assign qAdrs = {1'b0, lpRowF'(rRow), lpBankF'(rBank), lpColF'(rCol), 2'b00};

	// --------------------
	// counters
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST || iClr)
		begin
			rRow      <= '0;
			rCol      <= '0;
			rBank     <= '0;
			rAdrsDone <= 1'b0;
		end
		else
		begin
			if (iStep)   rRow  <= rRow + lpRowStep;   // row moves every beat
			if (qRowMax) rCol  <= rCol + lpColStep;   // next burst on row wrap
			if (qColMax) rBank <= rBank + 1'b1;       // next bank on column wrap
			rAdrsDone <= qAdrsMax;                    // all fields wrap together
		end
	end

	// hold the taken address for the pattern stage
	always_ff @(posedge iCLK)
	begin
		if (iStep)
			rAdrs <= qAdrs;
	end

	assign oAdrs     = rAdrs;
	assign oAdrsDone = rAdrsDone;

endmodule

// File: hdl/memtest_pkg.sv
`include "memtest_consts.svh"

package memtest_pkg;

	// full controller address, cs at the top, datapath bits at the bottom
	typedef logic [`MT_ADRS_BITS-1:0] adrs_t;

	// one memory word
	typedef logic [`MT_DATA_BITS-1:0] data_t;

	// data pattern selection
	typedef enum logic [1:0]
	{
		PAT_ADRS     = 2'd0,  // address twice, xor seed twice
		PAT_INV_ADRS = 2'd1,  // inverse of the above
		PAT_WALK     = 2'd2,  // walking one by word index
		PAT_SEED     = 2'd3   // seed twice
	} patMode_t;

	// test sequencer
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		WRITE = 2'd1,  // write pass
		READ  = 2'd2,  // read pass
		DRAIN = 2'd3   // wait for last reads
	} seqState_t;

endpackage

// File: include/memtest_consts.svh
`ifndef MEMTEST_CONSTS_SVH
`define MEMTEST_CONSTS_SVH

// --------------------
// ddr address layout
// --------------------
`define MT_ADRS_BITS     33  // cs + row + bank + col + datapath
`define MT_ROW_MAX_BITS  17  // hard ip row field
`define MT_ROW_BITS      14  // rows actually swept
`define MT_COL_BITS      10
`define MT_BANK_BITS     3

// default steps
`define MT_BUS_BYTES     64  // 512 bit bus, one row step per beat
`define MT_BURST         16  // column step on row wrap

// --------------------
// datapath
// --------------------
`define MT_DATA_BITS     64
`define MT_INFLIGHT      4   // outstanding reads allowed
`define MT_ERRCNT_BITS   16

`endif
